// File: src.f
+incdir+hw
hw/rv_pkg.sv
hw/stage_reg.sv
hw/pipe_control.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/mem_unit.sv
hw/rv_core.sv
sim/rv_core_sva.sv
sim/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= rv_core_tb
BUILD_DIR ?= obj_dir
FILELIST ?= src.f
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/rv_core_tb.sv
/* random RV32 subset program checked against an in-order model; data memory
   is 256 words, so generated accesses stay below address 160 */
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_core_tb import rv_pkg::*; ();

  localparam int n_rand = 64;
  localparam int n_prog = n_rand + 8;
  localparam int limit = n_rand * 5 * 4 + 8 * 5 * 4 + 100;

  logic       clock = 1'b0;
  logic       reset;
  logic       fetch_ready;
  logic       mem_ready;
  logic       fetch_valid;
  logic       mem_valid;
  word_t      fetch_addr;
  fetch_rsp_t fetch_data;
  mem_req_t   mem_req;
  word_t      mem_rdata;
  word_t      prog [n_prog];
  word_t      dmem [256];
  word_t      ref_mem [256];
  word_t      ref_regs [32];
  mem_req_t   exp_q [$];
  logic       exp_load_q [$];
  logic [31:0] lcg_state = 32'h1de56229;
  word_t      next_fetch;
  word_t      idle_start;
  int         cycles = 0;
  int         seen = 0;
  int         total;
  int         reset_err = 0;
  int         fetch_err = 0;
  int         access_err = 0;
  int         failed;

  always #20 clock = ~clock;

  rv_core UUT (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
  endfunction

  function automatic fetch_rsp_t fetch_word(word_t addr);
    word_t idx;
    idx = addr >> 2;
    // NOP fill past the program
    return (idx < word_t'(n_prog)) ? prog[idx] : 32'h0000_0013;
  endfunction

  assign fetch_data = fetch_word(fetch_addr);
  assign mem_rdata  = dmem[mem_req.addr[9:2]];

  task automatic check_word(input string name, input word_t got, input word_t exp,
                            inout int errs);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      errs++;
    end
  endtask

  task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp,
                           input logic cmp_data, inout int errs);
    if (got.addr !== exp.addr || got.write !== exp.write ||
        (cmp_data && got.wdata !== exp.wdata)) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      errs++;
    end
  endtask

  // sources lean on the two newest destinations
  function automatic reg_addr_t pick_src(reg_addr_t last, reg_addr_t prev);
    logic [31:0] r;
    r = lcg_next() % 4;
    if (r == 0) return last;
    if (r == 1) return prev;
    return reg_addr_t'(lcg_next() % 8);
  endfunction

  task automatic build_program();
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   last_rd = '0;
    reg_addr_t   prev_rd = '0;
    logic [11:0] imm;
    logic [31:0] kind;
    for (int i = 0; i < n_rand; i++) begin
      kind = lcg_next() % 8;
      rd   = reg_addr_t'(lcg_next() % 8);
      rs1  = pick_src(last_rd, prev_rd);
      rs2  = pick_src(last_rd, prev_rd);
      imm  = 12'((lcg_next() % 16) * 4);
      case (kind)
        0: prog[i] = {7'b0000000, rs2, rs1, 3'b000, rd, opc_op};
        1: prog[i] = {7'b0100000, rs2, rs1, 3'b000, rd, opc_op};
        2: prog[i] = {7'b0000000, rs2, rs1, 3'b111, rd, opc_op};
        3: prog[i] = {7'b0000000, rs2, rs1, 3'b110, rd, opc_op};
        4: prog[i] = {7'b0000000, rs2, rs1, 3'b100, rd, opc_op};
        5: prog[i] = {12'(lcg_next()), rs1, 3'b000, rd, opc_op_imm};
        6: prog[i] = {imm, 5'd0, 3'b010, rd, opc_load};
        default: prog[i] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], opc_store};
      endcase
      if (kind != 7) begin
        prev_rd = last_rd;
        last_rd = rd;
      end
    end
    // dump x0..x7 to 128..156
    for (int i = 0; i < 8; i++) begin
      imm = 12'(128 + 4 * i);
      prog[n_rand + i] = {imm[11:5], 5'(i), 5'd0, 3'b010, imm[4:0], opc_store};
    end
  endtask

  task automatic run_model();
    word_t      w;
    word_t      a;
    word_t      b;
    word_t      res;
    word_t      addr;
    logic       wr;
    for (int i = 0; i < n_prog; i++) begin
      w   = prog[i];
      a   = ref_regs[w[19:15]];
      b   = ref_regs[w[24:20]];
      wr  = 1'b1;
      res = '0;
      case (w[6:0])
        opc_op: begin
          case ({w[31:25], w[14:12]})
            10'b0100000_000: res = a - b;
            10'b0000000_111: res = a & b;
            10'b0000000_110: res = a | b;
            10'b0000000_100: res = a ^ b;
            default:         res = a + b;
          endcase
        end
        opc_op_imm: res = a + {{20{w[31]}}, w[31:20]};
        opc_load: begin
          addr = a + {{20{w[31]}}, w[31:20]};
          res  = ref_mem[addr[9:2]];
          exp_q.push_back('{addr: addr, wdata: '0, write: 1'b0});
          exp_load_q.push_back(1'b1);
        end
        default: begin
          addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
          ref_mem[addr[9:2]] = b;
          exp_q.push_back('{addr: addr, wdata: b, write: 1'b1});
          exp_load_q.push_back(1'b0);
          wr = 1'b0;
        end
      endcase
      if (wr && w[11:7] != 5'd0) ref_regs[w[11:7]] = res;
    end
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (reset) begin
      if (cycles > 0 && (fetch_valid || mem_valid)) begin
        $display("valid raised during reset at cycle %0d", cycles);
        reset_err++;
      end
    end else begin
      if (fetch_valid && fetch_ready) begin
        check_word("fetch_addr", fetch_addr, next_fetch, fetch_err);
        next_fetch <= next_fetch + 4;
      end
      if (mem_valid && mem_ready) begin
        if (exp_q.size() == 0) begin
          $display("unexpected data memory access at address %h", mem_req.addr);
          access_err++;
        end else begin
          check_req("mem_req", mem_req, exp_q[0], !exp_load_q[0], access_err);
          void'(exp_q.pop_front());
          void'(exp_load_q.pop_front());
        end
        seen <= seen + 1;
        if (mem_req.write) dmem[mem_req.addr[9:2]] <= mem_req.wdata;
      end
    end
  end

  initial begin
    while (cycles < limit) @(posedge clock);
    $display("timeout after %0d cycles with %0d accesses seen", cycles, seen);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    fetch_ready = 1'b0;
    mem_ready   = 1'b0;
    next_fetch  = `RV_RESET_PC;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    for (int i = 0; i < 256; i++) begin
      dmem[i]    = word_t'(i * 4) ^ 32'h5a5a0000;
      ref_mem[i] = dmem[i];
    end
    build_program();
    run_model();
    total = exp_q.size();
    repeat (10) @(posedge clock);
    #2 reset = 1'b0;
    while (seen < total) begin
      @(posedge clock);
      #2;
      fetch_ready = (lcg_next() % 10) < 6;
      mem_ready   = (lcg_next() % 10) < 6;
    end
    // idle NOPs must not touch memory and fetch keeps streaming
    fetch_ready = 1'b1;
    mem_ready   = 1'b1;
    idle_start  = next_fetch;
    repeat (20) @(posedge clock);
    if (next_fetch < idle_start + 32'd40) begin
      $display("fetch stalled while idle at address %h", next_fetch);
      fetch_err++;
    end
    $display("reset_valids: %s", (reset_err == 0) ? "pass" : "fail");
    $display("fetch_order: %s", (fetch_err == 0) ? "pass" : "fail");
    $display("access_stream: %s", (access_err == 0) ? "pass" : "fail");
    failed = int'(reset_err != 0) + int'(fetch_err != 0) + int'(access_err != 0);
    $display("tests 3, failed %0d, errors %0d, accesses %0d of %0d", failed,
             reset_err + fetch_err + access_err, seen, total);
    if (failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/rv_core_sva.sv
/* port rules of rv_core; bound into every instance of the core */
`timescale 1ns/1ns
`default_nettype none

module rv_core_sva import rv_pkg::*; (
  input logic     clock,
  input logic     reset,
  input logic     fetch_valid,
  input word_t    fetch_addr,
  input logic     fetch_ready,
  input logic     mem_valid,
  input mem_req_t mem_req,
  input logic     mem_ready
);

  fetch_hold: assert property (@(posedge clock) disable iff (reset)
    fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_addr))
    else $error("fetch request changed before ready");

  mem_hold: assert property (@(posedge clock) disable iff (reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
    else $error("data request changed before ready");

  // one cycle after each reset edge
  reset_quiet: assert property (@(posedge clock)
    reset |=> !fetch_valid && !mem_valid)
    else $error("valid high during reset");

endmodule

bind rv_core rv_core_sva u_sva (.*);

`default_nettype wire

// File: hw/rv_core.sv
/* five stage RV32 subset core without branches; both memory ports use a
   valid/ready handshake with read data in the ready cycle */
`timescale 1ns/1ns
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  output logic       fetch_valid,
  output word_t      fetch_addr,
  input  logic       fetch_ready,
  input  fetch_rsp_t fetch_data,
  output logic       mem_valid,
  output mem_req_t   mem_req,
  input  logic       mem_ready,
  input  word_t      mem_rdata
);

  logic    fetch_enable;
  logic    fetch_advance;
  logic    id_advance;
  logic    ex_advance;
  logic    mem_advance;
  logic    wb_advance;
  logic    id_valid;
  logic    ex_valid;
  logic    mem_valid_stage;
  logic    wb_valid;
  logic    mem_enable;
  logic    mem_is_access;
  logic    wb_write;
  word_t   id_inst;
  id_ex_t  id_out;
  id_ex_t  ex_q;
  ex_mem_t ex_out;
  ex_mem_t mem_q;
  mem_wb_t wb_out;
  mem_wb_t wb_q;

  // retiring item writes the register file once
  assign wb_write = wb_advance && wb_q.rd_write;

  pipe_control u_pipe_control (
    .clock           (clock),
    .reset           (reset),
    .fetch_ready     (fetch_ready),
    .mem_ready       (mem_ready),
    .ex_is_load      (ex_q.is_load),
    .ex_rd           (ex_q.rd),
    .id_rs1          (id_out.rs1),
    .id_rs2          (id_out.rs2),
    .mem_is_access   (mem_is_access),
    .fetch_advance   (fetch_advance),
    .id_advance      (id_advance),
    .ex_advance      (ex_advance),
    .mem_advance     (mem_advance),
    .wb_advance      (wb_advance),
    .id_valid        (id_valid),
    .ex_valid        (ex_valid),
    .mem_valid_stage (mem_valid_stage),
    .wb_valid        (wb_valid),
    .fetch_enable    (fetch_enable),
    .mem_enable      (mem_enable)
  );

  fetch_unit u_fetch (
    .clock         (clock),
    .reset         (reset),
    .fetch_enable  (fetch_enable),
    .fetch_advance (fetch_advance),
    .fetch_ready   (fetch_ready),
    .fetch_data    (fetch_data),
    .fetch_valid   (fetch_valid),
    .fetch_addr    (fetch_addr),
    .id_inst       (id_inst)
  );

  decode_unit u_decode (
    .clock    (clock),
    .reset    (reset),
    .id_inst  (id_inst),
    .id_valid (id_valid),
    .wb_rd    (wb_q.rd),
    .wb_write (wb_write),
    .wb_data  (wb_q.wb_data),
    .id_out   (id_out)
  );

  stage_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clock   (clock),
    .advance (id_advance),
    .d       (id_out),
    .q       (ex_q)
  );

  execute_unit u_execute (
    .ex_in         (ex_q),
    .ex_valid      (ex_valid),
    .mem_fwd       (mem_q),
    .mem_fwd_valid (mem_valid_stage),
    .wb_fwd        (wb_q),
    .wb_fwd_valid  (wb_valid),
    .ex_out        (ex_out)
  );

  stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clock   (clock),
    .advance (ex_advance),
    .d       (ex_out),
    .q       (mem_q)
  );

  mem_unit u_mem (
    .mem_in        (mem_q),
    .mem_enable    (mem_enable),
    .mem_rdata     (mem_rdata),
    .mem_valid     (mem_valid),
    .mem_req       (mem_req),
    .mem_is_access (mem_is_access),
    .wb_out        (wb_out)
  );

  stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clock   (clock),
    .advance (mem_advance),
    .d       (wb_out),
    .q       (wb_q)
  );

endmodule

`default_nettype wire

// File: hw/mem_unit.sv
/* word accesses only; the request is held by the stage register until
   mem_ready, and load data is taken in that same cycle */
`timescale 1ns/1ns
`default_nettype none

module mem_unit import rv_pkg::*; (
  input  ex_mem_t  mem_in,
  input  logic     mem_enable,
  input  word_t    mem_rdata,
  output logic     mem_valid,
  output mem_req_t mem_req,
  output logic     mem_is_access,
  output mem_wb_t  wb_out
);

  assign mem_is_access = mem_in.is_load || mem_in.is_store;
  assign mem_valid     = mem_enable;

  always_comb begin
    mem_req = '0;
    if (mem_enable) begin
      mem_req.addr  = mem_in.result;
      mem_req.wdata = mem_in.store_data;
      mem_req.write = mem_in.is_store;
    end
  end

  // loaded word or ALU result
  always_comb begin
    wb_out.wb_data  = mem_in.is_load ? mem_rdata : mem_in.result;
    wb_out.rd       = mem_in.rd;
    wb_out.rd_write = mem_in.rd_write;
  end

endmodule

`default_nettype wire

// File: hw/execute_unit.sv
/* operand forwarding and ALU; a load is never forwarded from the memory
   stage since pipe_control keeps its user out of execute until it leaves */
`timescale 1ns/1ns
`default_nettype none

module execute_unit import rv_pkg::*; (
  input  id_ex_t  ex_in,
  input  logic    ex_valid,
  input  ex_mem_t mem_fwd,
  input  logic    mem_fwd_valid,
  input  mem_wb_t wb_fwd,
  input  logic    wb_fwd_valid,
  output ex_mem_t ex_out
);

  word_t op_a;
  word_t rs2_val;
  word_t alu_b;
  word_t alu_y;

  // newest producer first
  function automatic word_t fwd(reg_addr_t rs, word_t reg_val);
    if (rs == '0) begin
      return reg_val;
    end else if (mem_fwd_valid && mem_fwd.rd_write && mem_fwd.rd == rs) begin
      return mem_fwd.result;
    end else if (wb_fwd_valid && wb_fwd.rd_write && wb_fwd.rd == rs) begin
      return wb_fwd.wb_data;
    end
    return reg_val;
  endfunction

  always_comb begin
    op_a    = fwd(ex_in.rs1, ex_in.rs1_data);
    rs2_val = fwd(ex_in.rs2, ex_in.rs2_data);
    alu_b   = ex_in.use_imm ? ex_in.imm : rs2_val;
  end

  always_comb begin
    case (ex_in.alu_op)
      alu_add: alu_y = op_a + alu_b;
      alu_sub: alu_y = op_a - alu_b;
      alu_and: alu_y = op_a & alu_b;
      alu_or:  alu_y = op_a | alu_b;
      alu_xor: alu_y = op_a ^ alu_b;
      default: alu_y = alu_b;
    endcase
  end

  // result doubles as the address of loads and stores
  always_comb begin
    ex_out.result     = alu_y;
    ex_out.store_data = rs2_val;
    ex_out.is_load    = ex_in.is_load && ex_valid;
    ex_out.is_store   = ex_in.is_store && ex_valid;
    ex_out.rd         = ex_in.rd;
    ex_out.rd_write   = ex_in.rd_write && ex_valid;
  end

endmodule

`default_nettype wire

// File: hw/decode_unit.sv
/* decodes ADD SUB AND OR XOR ADDI LW SW; anything else becomes a bubble
   that writes nothing; registers clear to zero on reset */
`timescale 1ns/1ns
`default_nettype none

module decode_unit import rv_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  word_t     id_inst,
  input  logic      id_valid,
  input  reg_addr_t wb_rd,
  input  logic      wb_write,
  input  word_t     wb_data,
  output id_ex_t    id_out
);

  word_t     regs [NREGS];
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm_i;
  word_t     imm_s;
  word_t     rs1_val;
  word_t     rs2_val;
  alu_op_t   r_op;
  logic      r_ok;

  assign opcode = id_inst[6:0];
  assign rd     = id_inst[11:7];
  assign funct3 = id_inst[14:12];
  assign rs1    = id_inst[19:15];
  assign rs2    = id_inst[24:20];
  assign funct7 = id_inst[31:25];
  assign imm_i  = {{(XLEN-12){id_inst[31]}}, id_inst[31:20]};
  assign imm_s  = {{(XLEN-12){id_inst[31]}}, id_inst[31:25], id_inst[11:7]};

  // x0 reads zero, a same-cycle writeback goes straight to the read
  assign rs1_val = (rs1 == '0) ? '0 : (wb_write && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : (wb_write && wb_rd == rs2) ? wb_data : regs[rs2];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_write) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // register-register ops
  always_comb begin
    r_ok = 1'b1;
    r_op = alu_add;
    case ({funct7, funct3})
      10'b0000000_000: r_op = alu_add;
      10'b0100000_000: r_op = alu_sub;
      10'b0000000_100: r_op = alu_xor;
      10'b0000000_110: r_op = alu_or;
      10'b0000000_111: r_op = alu_and;
      default:         r_ok = 1'b0;
    endcase
  end

  always_comb begin
    id_out          = '0;
    id_out.rs1_data = rs1_val;
    id_out.rs2_data = rs2_val;
    id_out.imm      = imm_i;
    id_out.alu_op   = alu_pass_b;
    id_out.rd       = rd;
    case (opcode)
      opc_op: begin
        if (r_ok) begin
          id_out.rs1      = rs1;
          id_out.rs2      = rs2;
          id_out.alu_op   = r_op;
          id_out.rd_write = 1'b1;
        end
      end
      opc_op_imm, opc_load: begin
        if (funct3 == ((opcode == opc_load) ? 3'b010 : 3'b000)) begin
          id_out.rs1      = rs1;
          id_out.use_imm  = 1'b1;
          id_out.alu_op   = alu_add;
          id_out.is_load  = (opcode == opc_load);
          id_out.rd_write = 1'b1;
        end
      end
      opc_store: begin
        if (funct3 == 3'b010) begin
          id_out.rs1      = rs1;
          id_out.rs2      = rs2;
          id_out.imm      = imm_s;
          id_out.use_imm  = 1'b1;
          id_out.alu_op   = alu_add;
          id_out.is_store = 1'b1;
        end
      end
      default: ;
    endcase
    id_out.rd_write = id_out.rd_write && id_valid;
  end

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
/* sequential fetch only; the request is raised while decode can take the
   word, and the PC steps by 4 on each completed transfer */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit import rv_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       fetch_enable,
  input  logic       fetch_advance,
  input  logic       fetch_ready,
  input  fetch_rsp_t fetch_data,
  output logic       fetch_valid,
  output word_t      fetch_addr,
  output word_t      id_inst
);

  word_t pc;
  logic  transfer;

  assign fetch_valid = fetch_enable && fetch_advance;
  assign fetch_addr  = pc;
  assign transfer    = fetch_valid && fetch_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (transfer) begin
      pc <= pc + word_t'(4);
    end
  end

  // instruction word for decode
  always_ff @(posedge clock) begin
    if (transfer) begin
      id_inst <= word_t'(fetch_data);
    end
  end

endmodule

`default_nettype wire

// File: hw/pipe_control.sv
/* stage valid bits and handshakes; execute and memory move in lockstep,
   so execute never fills a bubble while the memory stage is blocked */
`timescale 1ns/1ns
`default_nettype none

module pipe_control import rv_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      fetch_ready,
  input  logic      mem_ready,
  input  logic      ex_is_load,
  input  reg_addr_t ex_rd,
  input  reg_addr_t id_rs1,
  input  reg_addr_t id_rs2,
  input  logic      mem_is_access,
  output logic      fetch_advance,
  output logic      id_advance,
  output logic      ex_advance,
  output logic      mem_advance,
  output logic      wb_advance,
  output logic      id_valid,
  output logic      ex_valid,
  output logic      mem_valid_stage,
  output logic      wb_valid,
  output logic      fetch_enable,
  output logic      mem_enable
);

  logic fetch_run;
  logic wb_retire;
  logic load_use;
  logic fetch_done;
  logic mem_ready_go;
  logic mem_allowin;
  logic ex_allowin;
  logic id_allowin;

  // load in execute feeding the instruction in decode
  assign load_use = ex_valid && ex_is_load && (ex_rd != '0) &&
                    ((ex_rd == id_rs1) || (ex_rd == id_rs2));

  assign mem_ready_go = !mem_is_access || mem_ready;
  assign mem_allowin  = !mem_valid_stage || mem_ready_go;
  assign ex_allowin   = mem_allowin;
  assign id_allowin   = !id_valid || (!load_use && ex_allowin);

  assign fetch_enable  = fetch_run;
  assign fetch_advance = id_allowin;
  assign fetch_done    = fetch_enable && fetch_advance && fetch_ready;
  assign id_advance    = id_valid && !load_use && ex_allowin;
  assign ex_advance    = ex_valid && mem_allowin;
  assign mem_advance   = mem_valid_stage && mem_ready_go;
  assign wb_advance    = wb_retire;
  assign mem_enable    = mem_valid_stage && mem_is_access;

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_run       <= 1'b0;
      id_valid        <= 1'b0;
      ex_valid        <= 1'b0;
      mem_valid_stage <= 1'b0;
      wb_valid        <= 1'b0;
      wb_retire       <= 1'b0;
    end else begin
      fetch_run <= 1'b1;
      if (id_allowin) begin
        id_valid <= fetch_done;
      end
      if (ex_allowin) begin
        ex_valid <= id_advance;
      end
      if (mem_allowin) begin
        mem_valid_stage <= ex_advance;
      end
      // writeback keeps its last item for forwarding until replaced
      wb_retire <= mem_advance;
      if (mem_advance) begin
        wb_valid <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/stage_reg.sv
/* payload register between stages; no reset, the valid bits live in
   pipe_control */
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     advance,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clock) begin
    if (advance) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_pkg.sv
/* shared types of the core; needs rv_settings.svh on the include path */
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

  localparam int unsigned XLEN = `RV_XLEN;
  localparam int unsigned NREGS = `RV_NREGS;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [$clog2(NREGS)-1:0] reg_addr_t;

  localparam word_t RESET_PC = word_t'(`RV_RESET_PC);

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass_b
  } alu_op_t;

  // major opcodes kept by the decoder
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  typedef logic [31:0] fetch_rsp_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  write;
  } mem_req_t;

  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    logic      use_imm;
    alu_op_t   alu_op;
    logic      is_load;
    logic      is_store;
    reg_addr_t rd;
    logic      rd_write;
  } id_ex_t;

  typedef struct packed {
    word_t     result;
    word_t     store_data;
    logic      is_load;
    logic      is_store;
    reg_addr_t rd;
    logic      rd_write;
  } ex_mem_t;

  typedef struct packed {
    word_t     wb_data;
    reg_addr_t rd;
    logic      rd_write;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: hw/rv_settings.svh
/* core sizing; only RV32 with 32 registers is supported by the decoder
   and the reset PC must be word aligned */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
